//--- files.f
hw/ifu_pkg.sv
hw/mem_read_if.sv
hw/icache_array.sv
hw/axi_burst_reader.sv
hw/fetch_ctrl.sv
hw/ifu_top.sv
sim/axi_mem_model.sv
sim/tb_ifu.sv

//--- sim/tb_ifu.sv
`timescale 1ns/1ns
`default_nettype none

module tb_ifu;

  localparam int RANDOM_TRANSFERS = 3000;
  // five cycles per transfer plus margin for reset and the directed phases.
  localparam int CYCLE_LIMIT = RANDOM_TRANSFERS * 5 + 5000;
  localparam logic [31:0] SEED = 32'hea30_87dc;

  logic                clock = 1'b0;
  logic                reset;
  ifu_pkg::addr_t      npc;
  logic                clear_pipeline;
  logic                clear_cache;
  logic                stall;
  logic                inst_valid;
  ifu_pkg::inst_t      inst;
  ifu_pkg::addr_t      ifu_pc;
  logic                idu_ready;
  logic                inst_addr_misaligned;
  logic                fetch_busy;
  ifu_pkg::addr_t      araddr;
  logic                arvalid;
  ifu_pkg::burst_len_t arlen;
  logic                arready;
  ifu_pkg::inst_t      rdata;
  logic                rvalid;
  logic                rlast;
  logic                rready;

  ifu_pkg::addr_t exp_pc = ifu_pkg::RESET_PC;
  int             transfer_count = 0;
  int             read_count = 0;
  int             error_count = 0;
  int             cycle_count = 0;
  logic           held = 1'b0;
  ifu_pkg::inst_t held_inst;
  ifu_pkg::addr_t held_pc;
  logic           mis_clear_due = 1'b0;
  logic           uc_read_open = 1'b0;
  ifu_pkg::addr_t uc_read_addr;
  ifu_pkg::addr_t watch_addr = '1;
  int             watch_count = 0;
  logic           stall_on = 1'b0;
  logic           burst_open = 1'b0;

  always #20 clock = ~clock;

  ifu_top #(
    .SET_BITS(2)
  ) dut_i (
    .clock(clock), .reset(reset), .npc(npc), .clear_pipeline(clear_pipeline),
    .clear_cache(clear_cache), .stall(stall), .inst_valid(inst_valid), .inst(inst),
    .ifu_pc(ifu_pc), .idu_ready(idu_ready), .inst_addr_misaligned(inst_addr_misaligned),
    .fetch_busy(fetch_busy), .araddr(araddr), .arvalid(arvalid), .arlen(arlen),
    .arready(arready), .rdata(rdata), .rvalid(rvalid), .rlast(rlast), .rready(rready)
  );

  axi_mem_model mem_model_i (
    .clock(clock), .reset(reset), .araddr(araddr), .arvalid(arvalid), .arlen(arlen),
    .arready(arready), .rdata(rdata), .rvalid(rvalid), .rlast(rlast), .rready(rready)
  );

  function automatic ifu_pkg::inst_t expected_word(input ifu_pkg::addr_t a);
    return ((a >> 2) * 32'h9e37_79b1) ^ 32'h5a5a_0000;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("FAILED %s: got %h, expected %h", name, got, want);
    error_count++;
  endtask

  task automatic report_error(input string what);
    $display("ERROR at cycle %0d: %s", cycle_count, what);
    error_count++;
  endtask

  // reference model and checks sample before the edge updates the dut.
  always @(posedge clock) begin
    if (!reset) begin
      if (mis_clear_due && inst_addr_misaligned) begin
        report_error("misalignment report did not clear on redirect");
      end
      if (inst_addr_misaligned) begin
        if (ifu_pc !== exp_pc) report_mismatch("ifu_pc", ifu_pc, exp_pc);
        if (exp_pc[1:0] == 2'b00) report_error("misalignment reported for aligned pc");
        if (arvalid) report_error("read issued while pc is misaligned");
        if (inst_valid) report_error("instruction offered while pc is misaligned");
      end
      if (inst_valid && idu_ready) begin
        if (ifu_pc !== exp_pc) report_mismatch("ifu_pc", ifu_pc, exp_pc);
        if (inst !== expected_word(exp_pc)) report_mismatch("inst", inst, expected_word(exp_pc));
        if (ifu_pc[31:24] == ifu_pkg::UNCACHED_TOP) begin
          if (!uc_read_open || uc_read_addr !== ifu_pc) begin
            report_error("uncached instruction delivered without its own read");
          end
          uc_read_open = 1'b0;
        end
        exp_pc = exp_pc + 32'd4;
        transfer_count++;
      end
      if (held) begin
        if (!inst_valid) report_error("inst_valid dropped before the decoder took it");
        if (inst !== held_inst) report_mismatch("inst", inst, held_inst);
        if (ifu_pc !== held_pc) report_mismatch("ifu_pc", ifu_pc, held_pc);
      end
      held = inst_valid && !idu_ready && !clear_pipeline;
      held_inst = inst;
      held_pc = ifu_pc;
      // rready spans the data phase, fetch_busy the whole read after its request.
      if (rready !== burst_open) report_mismatch("rready", rready, burst_open);
      if (fetch_busy !== (arvalid || burst_open)) begin
        report_mismatch("fetch_busy", fetch_busy, arvalid || burst_open);
      end
      if (rvalid && rready && rlast) burst_open = 1'b0;
      if (arvalid && arready) begin
        read_count++;
        burst_open = 1'b1;
        if (araddr[31:24] == ifu_pkg::UNCACHED_TOP) begin
          if (arlen !== 8'd0) report_mismatch("arlen", arlen, 32'd0);
          uc_read_open = 1'b1;
          uc_read_addr = araddr;
        end else begin
          if (arlen !== 8'd3) report_mismatch("arlen", arlen, 32'd3);
          if (araddr[3:0] !== 4'h0) report_mismatch("araddr", araddr, {araddr[31:4], 4'h0});
        end
        if (araddr == watch_addr) watch_count++;
      end
      mis_clear_due = clear_pipeline;
      if (clear_pipeline) exp_pc = npc;
    end
  end

  task automatic next_cycle();
    @(negedge clock);
    clear_pipeline = 1'b0;
    clear_cache = 1'b0;
    idu_ready = ($urandom % 4) != 0;
    stall = stall_on && (($urandom % 16) == 0);
  endtask

  task automatic set_redirect(input ifu_pkg::addr_t target);
    npc = target;
    clear_pipeline = 1'b1;
    // nothing is handed over in the redirect cycle.
    idu_ready = 1'b0;
  endtask

  task automatic redirect_to(input ifu_pkg::addr_t target);
    next_cycle();
    set_redirect(target);
  endtask

  task automatic flush_cache();
    next_cycle();
    clear_cache = 1'b1;
  endtask

  task automatic wait_transfers(input int n);
    int target;
    target = transfer_count + n;
    while (transfer_count < target) next_cycle();
  endtask

  function automatic ifu_pkg::addr_t random_target();
    int unsigned kind;
    kind = $urandom % 16;
    if (kind == 0) return 32'h3000_0001 + ($urandom % 64) * 4 + ($urandom % 3);
    if (kind < 3) return 32'h0f00_0000 + ($urandom % 64) * 4;
    return 32'h3000_0000 + ($urandom % 32) * 4;
  endfunction

  initial begin
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("timeout after %0d cycles with %0d instructions transferred",
             cycle_count, transfer_count);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    int unsigned seed_draw;
    int          start_reads;
    int          start_watch;
    int          rep;
    int          waited;
    int          target;
    int unsigned pick;
    seed_draw = $urandom(SEED);
    reset = 1'b1;
    npc = ifu_pkg::RESET_PC;
    clear_pipeline = 1'b0;
    clear_cache = 1'b0;
    stall = 1'b0;
    idu_ready = 1'b0;
    repeat (16) @(negedge clock);
    reset = 1'b0;
    if (inst_valid || arvalid || rready || fetch_busy || inst_addr_misaligned) begin
      report_error("outputs not idle after reset");
    end

    wait_transfers(40);

    // the sram region is read again on every pass.
    start_reads = read_count;
    redirect_to(32'h0f00_0040);
    wait_transfers(8);
    redirect_to(32'h0f00_0040);
    wait_transfers(8);
    if (read_count - start_reads < 16) report_error("uncached words were not read each time");

    // one line fetched four times needs one burst.
    watch_addr = 32'h3000_0200;
    flush_cache();
    start_watch = watch_count;
    for (rep = 0; rep < 4; rep++) begin
      redirect_to(watch_addr);
      wait_transfers(4);
    end
    if (watch_count - start_watch != 1) report_error("cached line was not reused");
    flush_cache();
    start_watch = watch_count;
    redirect_to(watch_addr);
    wait_transfers(4);
    if (watch_count - start_watch != 1) report_error("invalidate did not cause one refill");

    // redirect while the new line is still being filled.
    flush_cache();
    redirect_to(32'h3000_0400);
    while (!(fetch_busy && araddr === 32'h3000_0400)) next_cycle();
    set_redirect(32'h3000_0480);
    wait_transfers(4);

    redirect_to(32'h3000_0106);
    waited = 0;
    while (!inst_addr_misaligned && waited < 40) begin
      next_cycle();
      waited++;
    end
    if (!inst_addr_misaligned) report_error("misaligned pc was not reported");
    repeat (8) next_cycle();
    redirect_to(32'h3000_0100);
    wait_transfers(4);

    stall_on = 1'b1;
    target = transfer_count + RANDOM_TRANSFERS;
    while (transfer_count < target) begin
      pick = $urandom % 64;
      if (pick == 0) begin
        redirect_to(random_target());
      end else if (pick == 1) begin
        flush_cache();
      end else begin
        next_cycle();
      end
    end
    stall_on = 1'b0;
    repeat (4) next_cycle();

    $display("transfers %0d, reads %0d, errors %0d", transfer_count, read_count, error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/axi_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

// axi read slave with a computed memory content and random gaps.
module axi_mem_model (
  input  logic                clock,
  input  logic                reset,
  input  ifu_pkg::addr_t      araddr,
  input  logic                arvalid,
  input  ifu_pkg::burst_len_t arlen,
  output logic                arready,
  output ifu_pkg::inst_t      rdata,
  output logic                rvalid,
  output logic                rlast,
  input  logic                rready
);

  logic                busy;
  logic                r_hold;
  ifu_pkg::addr_t      addr;
  ifu_pkg::burst_len_t beats_left;

  function automatic ifu_pkg::inst_t word_at(input ifu_pkg::addr_t a);
    return ((a >> 2) * 32'h9e37_79b1) ^ 32'h5a5a_0000;
  endfunction

  initial begin
    arready = 1'b0;
    rvalid = 1'b0;
    rlast = 1'b0;
    rdata = '0;
    busy = 1'b0;
    r_hold = 1'b0;
    addr = '0;
    beats_left = '0;
  end

  // handshakes are taken at the rising edge.
  always @(posedge clock) begin
    if (reset) begin
      busy = 1'b0;
      r_hold = 1'b0;
    end else begin
      r_hold = rvalid && !rready;
      if (arvalid && arready) begin
        busy = 1'b1;
        addr = araddr;
        beats_left = arlen;
      end
      if (rvalid && rready) begin
        if (rlast) begin
          busy = 1'b0;
        end else begin
          addr = addr + 32'd4;
          beats_left = beats_left - 8'd1;
        end
      end
    end
  end

  // outputs change on the falling edge.
  always @(negedge clock) begin
    if (reset) begin
      arready = 1'b0;
      rvalid = 1'b0;
      rlast = 1'b0;
    end else begin
      arready = !busy && (($urandom % 4) != 0);
      // a beat that was offered stays until taken.
      if (!r_hold) begin
        rvalid = busy && (($urandom % 8) != 0);
      end
      rlast = rvalid && (beats_left == 0);
      rdata = rvalid ? word_at(addr) : '0;
    end
  end

endmodule

`default_nettype wire

//--- hw/ifu_top.sv
`timescale 1ns/1ns
`default_nettype none

module ifu_top #(
  parameter int SET_BITS = 2
) (
  input  logic                clock,
  input  logic                reset,
  input  ifu_pkg::addr_t      npc,
  input  logic                clear_pipeline,
  input  logic                clear_cache,
  input  logic                stall,
  output logic                inst_valid,
  output ifu_pkg::inst_t      inst,
  output ifu_pkg::addr_t      ifu_pc,
  input  logic                idu_ready,
  output logic                inst_addr_misaligned,
  output logic                fetch_busy,
  output ifu_pkg::addr_t      araddr,
  output logic                arvalid,
  output ifu_pkg::burst_len_t arlen,
  input  logic                arready,
  input  ifu_pkg::inst_t      rdata,
  input  logic                rvalid,
  input  logic                rlast,
  output logic                rready
);

  localparam int TAG_BITS = 32 - ifu_pkg::LINE_OFFSET_BITS - SET_BITS;

  ifu_pkg::addr_t      lookup_addr;
  logic                hit;
  ifu_pkg::inst_t      hit_word;
  logic                fill_valid;
  logic [SET_BITS-1:0] fill_index;
  logic [TAG_BITS-1:0] fill_tag;
  ifu_pkg::inst_t      fill_data;
  logic                fill_last;
  logic                invalidate;

  mem_read_if mem_i ();

  fetch_ctrl #(
    .SET_BITS(SET_BITS)
  ) fetch_ctrl_i (
    .clock                (clock),
    .reset                (reset),
    .npc                  (npc),
    .clear_pipeline       (clear_pipeline),
    .clear_cache          (clear_cache),
    .stall                (stall),
    .inst_valid           (inst_valid),
    .inst                 (inst),
    .ifu_pc               (ifu_pc),
    .idu_ready            (idu_ready),
    .inst_addr_misaligned (inst_addr_misaligned),
    .fetch_busy           (fetch_busy),
    .lookup_addr          (lookup_addr),
    .hit                  (hit),
    .hit_word             (hit_word),
    .fill_valid           (fill_valid),
    .fill_index           (fill_index),
    .fill_tag             (fill_tag),
    .fill_data            (fill_data),
    .fill_last            (fill_last),
    .invalidate           (invalidate),
    .mem                  (mem_i.requester)
  );

  icache_array #(
    .SET_BITS(SET_BITS)
  ) icache_array_i (
    .clock       (clock),
    .reset       (reset),
    .invalidate  (invalidate),
    .lookup_addr (lookup_addr),
    .hit         (hit),
    .hit_word    (hit_word),
    .fill_valid  (fill_valid),
    .fill_index  (fill_index),
    .fill_tag    (fill_tag),
    .fill_data   (fill_data),
    .fill_last   (fill_last)
  );

  axi_burst_reader axi_burst_reader_i (
    .clock   (clock),
    .reset   (reset),
    .mem     (mem_i.reader),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arlen   (arlen),
    .arready (arready),
    .rdata   (rdata),
    .rvalid  (rvalid),
    .rlast   (rlast),
    .rready  (rready)
  );

endmodule

`default_nettype wire

//--- hw/fetch_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_ctrl #(
  parameter int SET_BITS = 2,
  localparam int TAG_BITS = 32 - ifu_pkg::LINE_OFFSET_BITS - SET_BITS
) (
  input  logic                clock,
  input  logic                reset,
  input  ifu_pkg::addr_t      npc,
  input  logic                clear_pipeline,
  input  logic                clear_cache,
  input  logic                stall,
  output logic                inst_valid,
  output ifu_pkg::inst_t      inst,
  output ifu_pkg::addr_t      ifu_pc,
  input  logic                idu_ready,
  output logic                inst_addr_misaligned,
  output logic                fetch_busy,
  output ifu_pkg::addr_t      lookup_addr,
  input  logic                hit,
  input  ifu_pkg::inst_t      hit_word,
  output logic                fill_valid,
  output logic [SET_BITS-1:0] fill_index,
  output logic [TAG_BITS-1:0] fill_tag,
  output ifu_pkg::inst_t      fill_data,
  output logic                fill_last,
  output logic                invalidate,
  mem_read_if.requester       mem
);

  localparam int LOB = ifu_pkg::LINE_OFFSET_BITS;

  ifu_pkg::fetch_state_t state;
  ifu_pkg::addr_t        pc;
  ifu_pkg::addr_t        miss_addr;
  logic                  miss_uncached;
  logic                  discard;
  logic                  misaligned;
  logic                  out_free;
  logic                  fill_done;

  // output slot is empty or hands its instruction over this cycle.
  assign out_free = !inst_valid || idu_ready;

  assign lookup_addr = pc;
  assign fetch_busy = (state == ifu_pkg::FETCH_FILL);
  assign inst_addr_misaligned = misaligned;
  assign invalidate = clear_cache;

  assign mem.req_valid = (state == ifu_pkg::FETCH_REQUEST);
  assign mem.req_addr = miss_uncached ? miss_addr : {miss_addr[31:LOB], {LOB{1'b0}}};
  assign mem.req_len = miss_uncached ? '0 : ifu_pkg::burst_len_t'(ifu_pkg::WORDS_PER_LINE - 1);

  // fill beats use the latched miss address, not the current pc.
  assign fill_valid = fetch_busy && mem.beat_valid && !miss_uncached;
  assign fill_index = miss_addr[LOB +: SET_BITS];
  assign fill_tag = miss_addr[31 -: TAG_BITS];
  assign fill_data = mem.beat_data;
  assign fill_last = mem.beat_last;

  assign fill_done = fetch_busy && mem.beat_valid && mem.beat_last;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= ifu_pkg::FETCH_LOOKUP;
      pc <= ifu_pkg::RESET_PC;
      inst_valid <= 1'b0;
      misaligned <= 1'b0;
      discard <= 1'b0;
    end else begin
      if (idu_ready) begin
        inst_valid <= 1'b0;
      end
      case (state)
        ifu_pkg::FETCH_LOOKUP: begin
          if (!clear_pipeline && !stall && !misaligned && out_free) begin
            if (pc[1:0] != 2'b00) begin
              misaligned <= 1'b1;
              ifu_pc <= pc;
            end else if (hit) begin
              inst <= hit_word;
              ifu_pc <= pc;
              inst_valid <= 1'b1;
              pc <= pc + 32'd4;
            end else begin
              miss_addr <= pc;
              miss_uncached <= (pc[31:24] == ifu_pkg::UNCACHED_TOP);
              state <= ifu_pkg::FETCH_REQUEST;
            end
          end
        end
        ifu_pkg::FETCH_REQUEST: begin
          if (mem.req_ready) begin
            state <= ifu_pkg::FETCH_FILL;
          end
        end
        ifu_pkg::FETCH_FILL: begin
          // uncached word goes straight to the decoder.
          if (mem.beat_valid && miss_uncached && !discard && !clear_pipeline) begin
            inst <= mem.beat_data;
            ifu_pc <= miss_addr;
            inst_valid <= 1'b1;
            pc <= miss_addr + 32'd4;
          end
          if (fill_done) begin
            state <= ifu_pkg::FETCH_LOOKUP;
            discard <= 1'b0;
          end
        end
        default: begin
          state <= ifu_pkg::FETCH_LOOKUP;
        end
      endcase
      // redirect wins; an open read still drains.
      if (clear_pipeline) begin
        pc <= npc;
        inst_valid <= 1'b0;
        misaligned <= 1'b0;
        if (state != ifu_pkg::FETCH_LOOKUP && !fill_done) begin
          discard <= 1'b1;
        end
      end
    end
  end

  decoder_outputs_hold: assert property (
    @(posedge clock) disable iff (reset)
    inst_valid && !idu_ready |=> $stable(inst) && $stable(ifu_pc)
  );

  request_with_empty_slot: assert property (
    @(posedge clock) disable iff (reset)
    mem.req_valid |-> !inst_valid
  );

  beats_only_in_fill: assert property (
    @(posedge clock) disable iff (reset)
    mem.beat_valid |-> state == ifu_pkg::FETCH_FILL
  );

endmodule

`default_nettype wire

//--- hw/axi_burst_reader.sv
`timescale 1ns/1ns
`default_nettype none

module axi_burst_reader (
  input  logic                clock,
  input  logic                reset,
  mem_read_if.reader          mem,
  output ifu_pkg::addr_t      araddr,
  output logic                arvalid,
  output ifu_pkg::burst_len_t arlen,
  input  logic                arready,
  input  ifu_pkg::inst_t      rdata,
  input  logic                rvalid,
  input  logic                rlast,
  output logic                rready
);

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ADDR,
    RD_DATA
  } rd_state_t;

  rd_state_t state;
  logic      beat_fire;

  assign mem.req_ready = (state == RD_IDLE);

  assign beat_fire = rvalid && rready;

  // beats pass straight through, the requester always takes them.
  assign mem.beat_valid = beat_fire;
  assign mem.beat_data = rdata;
  assign mem.beat_last = rlast;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= RD_IDLE;
      arvalid <= 1'b0;
      rready <= 1'b0;
    end else begin
      case (state)
        RD_IDLE: begin
          if (mem.req_valid) begin
            arvalid <= 1'b1;
            state <= RD_ADDR;
          end
        end
        RD_ADDR: begin
          if (arready) begin
            arvalid <= 1'b0;
            rready <= 1'b1;
            state <= RD_DATA;
          end
        end
        RD_DATA: begin
          if (beat_fire && rlast) begin
            rready <= 1'b0;
            state <= RD_IDLE;
          end
        end
        default: begin
          state <= RD_IDLE;
        end
      endcase
    end
  end

  // address and length are captured when the request is taken.
  always_ff @(posedge clock) begin
    if (state == RD_IDLE && mem.req_valid) begin
      araddr <= mem.req_addr;
      arlen <= mem.req_len;
    end
  end

  ar_held_until_ready: assert property (
    @(posedge clock) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen)
  );

endmodule

`default_nettype wire

//--- hw/icache_array.sv
`timescale 1ns/1ns
`default_nettype none

module icache_array #(
  parameter int SET_BITS = 2,
  localparam int TAG_BITS = 32 - ifu_pkg::LINE_OFFSET_BITS - SET_BITS
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                invalidate,
  input  ifu_pkg::addr_t      lookup_addr,
  output logic                hit,
  output ifu_pkg::inst_t      hit_word,
  input  logic                fill_valid,
  input  logic [SET_BITS-1:0] fill_index,
  input  logic [TAG_BITS-1:0] fill_tag,
  input  ifu_pkg::inst_t      fill_data,
  input  logic                fill_last
);

  localparam int NUM_SETS = 1 << SET_BITS;
  localparam int WORD_BITS = $bits(ifu_pkg::inst_t);
  localparam int LINE_BITS = $bits(ifu_pkg::line_t);

  typedef logic [TAG_BITS-1:0] tag_t;

  logic [NUM_SETS-1:0] valid;
  tag_t                tags [NUM_SETS];
  ifu_pkg::line_t      lines [NUM_SETS];

  ifu_pkg::line_t      fill_buf;
  ifu_pkg::line_t      fill_next;
  logic [2:0]          beat_count;

  logic [SET_BITS-1:0] lookup_set;
  tag_t                lookup_tag;
  logic                lookup_uncached;
  ifu_pkg::line_t      lookup_line;

  assign lookup_set = lookup_addr[ifu_pkg::LINE_OFFSET_BITS +: SET_BITS];
  assign lookup_tag = lookup_addr[31 -: TAG_BITS];
  assign lookup_uncached = (lookup_addr[31:24] == ifu_pkg::UNCACHED_TOP);
  assign lookup_line = lines[lookup_set];

  assign hit = valid[lookup_set] && (tags[lookup_set] == lookup_tag) && !lookup_uncached;

  // word select by address bits 3:2.
  assign hit_word = lookup_line[WORD_BITS * lookup_addr[3:2] +: WORD_BITS];

  // beats arrive lowest word first and shift in from the top.
  assign fill_next = {fill_data, fill_buf[LINE_BITS-1:WORD_BITS]};

  always_ff @(posedge clock) begin
    if (reset || invalidate) begin
      valid <= '0;
    end else if (fill_valid && fill_last) begin
      valid[fill_index] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      beat_count <= '0;
    end else if (fill_valid) begin
      if (fill_last) begin
        beat_count <= '0;
      end else begin
        beat_count <= beat_count + 3'd1;
      end
    end
  end

  // the line only becomes visible on the last beat.
  always_ff @(posedge clock) begin
    if (fill_valid) begin
      fill_buf <= fill_next;
      if (fill_last) begin
        lines[fill_index] <= fill_next;
        tags[fill_index] <= fill_tag;
      end
    end
  end

  fill_beats_bounded: assert property (
    @(posedge clock) disable iff (reset)
    fill_valid |-> beat_count < ifu_pkg::WORDS_PER_LINE
  );

endmodule

`default_nettype wire

//--- hw/mem_read_if.sv
`timescale 1ns/1ns
`default_nettype none

// one outstanding read at a time, beats are never back-pressured.
interface mem_read_if;

  logic               req_valid;
  logic               req_ready;
  ifu_pkg::addr_t     req_addr;
  ifu_pkg::burst_len_t req_len;

  logic               beat_valid;
  ifu_pkg::inst_t     beat_data;
  logic               beat_last;

  modport requester (
    output req_valid,
    output req_addr,
    output req_len,
    input  req_ready,
    input  beat_valid,
    input  beat_data,
    input  beat_last
  );

  modport reader (
    input  req_valid,
    input  req_addr,
    input  req_len,
    output req_ready,
    output beat_valid,
    output beat_data,
    output beat_last
  );

endinterface

`default_nettype wire

//--- hw/ifu_pkg.sv
`default_nettype none

package ifu_pkg;

  // byte address and instruction word.
  typedef logic [31:0] addr_t;
  typedef logic [31:0] inst_t;

  // one cache line holds four words, word 0 in the low bits.
  typedef logic [127:0] line_t;

  localparam int WORDS_PER_LINE = 4;
  localparam int LINE_OFFSET_BITS = 4;

  // first fetch address after reset.
  localparam addr_t RESET_PC = 32'h3000_0000;

  // top address byte of the on-chip sram, never cached.
  localparam logic [7:0] UNCACHED_TOP = 8'h0f;

  // axi beat count minus one.
  typedef logic [7:0] burst_len_t;

  typedef enum logic [1:0] {
    FETCH_LOOKUP,
    FETCH_REQUEST,
    FETCH_FILL
  } fetch_state_t;

endpackage

`default_nettype wire
